// ==== flist.f ====
hdl/vid_pkg.sv
hdl/lnk_pkg.sv
hdl/vid_src_sel.sv
hdl/vid_credit_fifo.sv
hdl/lnk_lane_packer.sv
hdl/dp_vid_lnk_top.sv
bench/tb_dp_vid_lnk.sv

// ==== Makefile ====
# Verilator build and run of the DisplayPort video path testbench

VERILATOR ?= verilator
TOP       ?= tb_dp_vid_lnk
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_dp_vid_lnk.sv ====
/* Testbench for the DisplayPort video path, external and colour-bar
   traffic checked word by word against a per-lane byte model */
`timescale 1ns/10ps
`default_nettype none

module tb_dp_vid_lnk;

localparam int CLK_PERIOD = 40;
localparam int SLOT       = lnk_pkg::SYM_SLOT_W;

// Cycles per test for reset, beats, drain and settle
localparam int T1_CYC = 4 + 32 + 24;
localparam int T3_CYC = 2 + 88 + 16;
localparam int T4_CYC = 4 + 11 + 26;
localparam int T5_CYC = 4 + 2 + 24;
localparam int WD_CYC = T1_CYC + T3_CYC + T4_CYC + T5_CYC + 200;

logic                           clk_from_vid_buf;
logic                           SYS_RSTN_IN;
logic                           src_sel_i;
logic                           ext_de_i;
logic [vid_pkg::COMP_W-1:0]     ext_r_i;
logic [vid_pkg::COMP_W-1:0]     ext_g_i;
logic [vid_pkg::COMP_W-1:0]     ext_b_i;
logic                           phy_rdy_i;
wire  [lnk_pkg::PHY_W-1:0]      phy_dat [0:lnk_pkg::LANES-1];
wire                            phy_vld_o;
wire                            ovf_o;

logic [7:0]     byte_q [0:lnk_pkg::LANES-1][$];     // Expected bytes per link lane
string          tname;
integer         seed;
int             err_cnt;
int             err_at_start;
int             test_cnt;
int             wcnt;           // Words checked in this test
int             n_acc;          // Beats taken by the buffer since reset
int             fmt_words;
int             fmt_err;
bit             chk_en;

dp_vid_lnk_top dut0
(
    .clk_from_vid_buf   (clk_from_vid_buf),
    .SYS_RSTN_IN        (SYS_RSTN_IN),
    .src_sel_i          (src_sel_i),
    .ext_de_i           (ext_de_i),
    .ext_r_i            (ext_r_i),
    .ext_g_i            (ext_g_i),
    .ext_b_i            (ext_b_i),
    .phy_rdy_i          (phy_rdy_i),
    .phy_dat0_o         (phy_dat[0]),
    .phy_dat1_o         (phy_dat[1]),
    .phy_dat2_o         (phy_dat[2]),
    .phy_dat3_o         (phy_dat[3]),
    .phy_vld_o          (phy_vld_o),
    .ovf_o              (ovf_o)
);

initial
begin
    clk_from_vid_buf = 1'b0;
    forever #(CLK_PERIOD / 2) clk_from_vid_buf = ~clk_from_vid_buf;
end

initial
begin
    #(WD_CYC * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYC);
    $display("Simulation failed");
    $finish;
end

// Data byte positions of the four symbol slots
function automatic logic [lnk_pkg::PHY_W-1:0] data_mask();
    logic [lnk_pkg::PHY_W-1:0] m;
    m = '0;
    for (int s = 0; s < lnk_pkg::SPL; s++)
        m[s*SLOT +: 8] = 8'hFF;
    return m;
endfunction

function automatic logic [23:0] bar_color(input int k);
    case ((k % vid_pkg::LINE_BEATS) / vid_pkg::BAR_BEATS)
        0       : return 24'hFFFFFF;    // White
        1       : return 24'hFFFF00;    // Yellow
        2       : return 24'h00FFFF;    // Cyan
        3       : return 24'h00FF00;    // Green
        4       : return 24'hFF00FF;    // Magenta
        5       : return 24'hFF0000;    // Red
        6       : return 24'h0000FF;    // Blue
        default : return 24'h000000;    // Black
    endcase
endfunction

// Lane L takes R, G, B of pixel L
task automatic model_push(input logic [31:0] r, input logic [31:0] g, input logic [31:0] b);
    for (int l = 0; l < lnk_pkg::LANES; l++)
    begin
        byte_q[l].push_back(r[l*8 +: 8]);
        byte_q[l].push_back(g[l*8 +: 8]);
        byte_q[l].push_back(b[l*8 +: 8]);
    end
endtask

task automatic model_bar(input int k);
    logic [23:0] c;
    c = bar_color(k);
    model_push({4{c[23:16]}}, {4{c[15:8]}}, {4{c[7:0]}});
endtask

task automatic report();
    $display("%s done, words=%0d errors=%0d", tname, wcnt, err_cnt - err_at_start);
    test_cnt++;
endtask

task automatic start_test(input string name, input bit sel, input bit rdy);
    @(negedge clk_from_vid_buf);
    chk_en = 1'b0;
    tname = name;
    src_sel_i = sel;
    phy_rdy_i = rdy;
    ext_de_i = 1'b0;
    SYS_RSTN_IN = 1'b0;
    repeat (2) @(negedge clk_from_vid_buf);
    SYS_RSTN_IN = 1'b1;
    assert (!phy_vld_o && !ovf_o)
    else
    begin
        $display("%s: phy_vld_o or ovf_o still high after reset", tname);
        err_cnt++;
    end
    for (int l = 0; l < lnk_pkg::LANES; l++)
        byte_q[l].delete();
    wcnt = 0;
    err_at_start = err_cnt;
    chk_en = 1'b1;
    n_acc = 0;
    if (sel)
    begin
        // Bar beats 0 and 1 go out while the select crosses its synchronizer
        model_bar(0);
        model_bar(1);
        n_acc = 2;
        repeat (2) @(negedge clk_from_vid_buf);
    end
endtask

// No pops while held back, so only FIFO_DEPTH beats fit when limited
task automatic send_beats(input int n, input bit limit_credit);
    logic [31:0] r;
    logic [31:0] g;
    logic [31:0] b;
    for (int i = 0; i < n; i++)
    begin
        r = $random(seed);
        g = $random(seed);
        b = $random(seed);
        ext_r_i = r;
        ext_g_i = g;
        ext_b_i = b;
        ext_de_i = 1'b1;
        if (!limit_credit || n_acc < vid_pkg::FIFO_DEPTH)
        begin
            model_push(r, g, b);
            n_acc++;
        end
        @(negedge clk_from_vid_buf);
    end
    ext_de_i = 1'b0;
endtask

task automatic wait_words(input int target, input int limit);
    int n;
    n = 0;
    while (wcnt < target && n < limit)
    begin
        @(negedge clk_from_vid_buf);
        n++;
    end
    assert (wcnt >= target)
    else
    begin
        $display("%s: timed out waiting for %0d words, got %0d", tname, target, wcnt);
        err_cnt++;
    end
endtask

// Every whole group of four modelled bytes must come out and no more
task automatic finish_test(input int limit);
    int target;
    target = wcnt + byte_q[0].size() / lnk_pkg::SPL;
    wait_words(target, limit);
    repeat (8) @(negedge clk_from_vid_buf);
    assert (wcnt == target)
    else
    begin
        $display("MISMATCH %s word count expected %0d actual %0d", tname, target, wcnt);
        err_cnt++;
    end
    report();
endtask

// Word checker samples settled outputs at the falling edge
always @(negedge clk_from_vid_buf)
begin : check_word
    logic [lnk_pkg::PHY_W-1:0] exp_w;
    logic [lnk_pkg::PHY_W-1:0] act_w;
    if (SYS_RSTN_IN && phy_vld_o)
    begin
        fmt_words++;
        for (int p = 0; p < lnk_pkg::LANES; p++)
        begin
            // K flags, spare bits, disparity and upper bits all zero
            assert ((phy_dat[p] & ~data_mask()) == '0)
            else
            begin
                $display("MISMATCH word_format word %0d expected %h actual %h",
                    p, {lnk_pkg::PHY_W{1'b0}}, phy_dat[p] & ~data_mask());
                fmt_err++;
                err_cnt++;
            end
        end
        if (chk_en)
        begin
            wcnt++;
            for (int l = 0; l < lnk_pkg::LANES; l++)
            begin
                act_w = phy_dat[lnk_pkg::LANE_MAP[l]] & data_mask();
                assert (byte_q[l].size() >= lnk_pkg::SPL)
                else
                begin
                    $display("%s: word on lane %0d with no bytes left to expect", tname, l);
                    err_cnt++;
                end
                if (byte_q[l].size() >= lnk_pkg::SPL)
                begin
                    exp_w = '0;
                    for (int s = 0; s < lnk_pkg::SPL; s++)
                        exp_w[s*SLOT +: 8] = byte_q[l].pop_front();  // Oldest byte first
                    assert (act_w == exp_w)
                    else
                    begin
                        $display("MISMATCH %s lane %0d expected %h actual %h",
                            tname, l, exp_w, act_w);
                        err_cnt++;
                    end
                end
            end
        end
    end
end

initial
begin
    seed = 42743;
    SYS_RSTN_IN = 1'b0;
    src_sel_i = 1'b0;
    ext_de_i = 1'b0;
    ext_r_i = '0;
    ext_g_i = '0;
    ext_b_i = '0;
    phy_rdy_i = 1'b0;
    err_cnt = 0;
    test_cnt = 0;
    wcnt = 0;
    fmt_words = 0;
    fmt_err = 0;
    chk_en = 1'b0;

    start_test("ext_pass", 1'b1, 1'b1);
    send_beats(32, 1'b0);
    finish_test(64);

    // 80 beats checked past the line wrap at 64
    start_test("colour_bars", 1'b0, 1'b1);
    for (int k = 0; k < 88; k++)
    begin
        model_bar(k);
    end
    wait_words(60, 100);
    chk_en = 1'b0;
    report();

    start_test("backpressure", 1'b1, 1'b0);
    send_beats(vid_pkg::FIFO_DEPTH + 3, 1'b1);
    @(negedge clk_from_vid_buf);
    assert (ovf_o)
    else
    begin
        $display("%s: ovf_o did not rise after beats were dropped", tname);
        err_cnt++;
    end
    assert (wcnt == 0)
    else
    begin
        $display("MISMATCH %s words while held expected 0 actual %0d", tname, wcnt);
        err_cnt++;
    end
    phy_rdy_i = 1'b1;
    finish_test(64);

    // Two bar beats and two external beats make exactly three words
    start_test("reset_state", 1'b1, 1'b1);
    send_beats(2, 1'b0);
    finish_test(64);

    $display("word_format done, words=%0d errors=%0d", fmt_words, fmt_err);
    test_cnt++;

    $display("tests=%0d errors=%0d", test_cnt, err_cnt);
    if (err_cnt == 0)
        $display("Simulation completed successfully");
    else
        $display("Simulation failed");
    $finish;
end

endmodule

`default_nettype wire

// ==== hdl/dp_vid_lnk_top.sv ====
/* DisplayPort transmit video path: source select, credit buffer and lane packer */
`timescale 1ns/10ps
`default_nettype none

module dp_vid_lnk_top
(
    input  wire                         clk_from_vid_buf,
    input  wire                         SYS_RSTN_IN,

    // Video in
    input  wire                         src_sel_i,
    input  wire                         ext_de_i,
    input  wire [vid_pkg::COMP_W-1:0]   ext_r_i,
    input  wire [vid_pkg::COMP_W-1:0]   ext_g_i,
    input  wire [vid_pkg::COMP_W-1:0]   ext_b_i,

    // PHY out
    input  wire                         phy_rdy_i,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat0_o,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat1_o,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat2_o,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat3_o,
    output wire                         phy_vld_o,
    output wire                         ovf_o
);

wire                            push;
wire [vid_pkg::BEAT_W-1:0]      push_dat;
wire                            crd_ret;
wire                            buf_vld;
wire [vid_pkg::BEAT_W-1:0]      buf_dat;
wire                            pop;

vid_src_sel src_sel_inst
(
    .clk_from_vid_buf   (clk_from_vid_buf),
    .SYS_RSTN_IN        (SYS_RSTN_IN),
    .src_sel_i          (src_sel_i),
    .ext_de_i           (ext_de_i),
    .ext_r_i            (ext_r_i),
    .ext_g_i            (ext_g_i),
    .ext_b_i            (ext_b_i),
    .crd_ret_i          (crd_ret),
    .push_o             (push),
    .push_dat_o         (push_dat),
    .ovf_o              (ovf_o)
);

vid_credit_fifo fifo_inst
(
    .clk_from_vid_buf   (clk_from_vid_buf),
    .SYS_RSTN_IN        (SYS_RSTN_IN),
    .push_i             (push),
    .push_dat_i         (push_dat),
    .pop_i              (pop),
    .buf_vld_o          (buf_vld),
    .buf_dat_o          (buf_dat),
    .crd_ret_o          (crd_ret)
);

lnk_lane_packer packer_inst
(
    .clk_from_vid_buf   (clk_from_vid_buf),
    .SYS_RSTN_IN        (SYS_RSTN_IN),
    .buf_vld_i          (buf_vld),
    .buf_dat_i          (buf_dat),
    .pop_o              (pop),
    .phy_rdy_i          (phy_rdy_i),
    .phy_dat0_o         (phy_dat0_o),
    .phy_dat1_o         (phy_dat1_o),
    .phy_dat2_o         (phy_dat2_o),
    .phy_dat3_o         (phy_dat3_o),
    .phy_vld_o          (phy_vld_o)
);

endmodule

`default_nettype wire

// ==== hdl/lnk_lane_packer.sv ====
/* Link lane packer: spreads pixel bytes over four lanes with a residue
   and formats each group of four symbols as an 80-bit PHY word */
`timescale 1ns/10ps
`default_nettype none

module lnk_lane_packer
(
    input  wire                         clk_from_vid_buf,
    input  wire                         SYS_RSTN_IN,

    // Pixel buffer
    input  wire                         buf_vld_i,
    input  wire [vid_pkg::BEAT_W-1:0]   buf_dat_i,
    output logic                        pop_o,

    // PHY
    input  wire                         phy_rdy_i,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat0_o,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat1_o,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat2_o,
    output wire [lnk_pkg::PHY_W-1:0]    phy_dat3_o,
    output logic                        phy_vld_o
);

logic [lnk_pkg::RES_W-1:0]      res_cnt;        // Bytes held per lane
logic [lnk_pkg::RES_W-1:0]      total;
logic                           emit;
logic [lnk_pkg::RES_DW-1:0]     res_dat [0:lnk_pkg::LANES-1];
logic [lnk_pkg::RES_DW-1:0]     res_nxt [0:lnk_pkg::LANES-1];
logic [lnk_pkg::CMB_DW-1:0]     res_ext [0:lnk_pkg::LANES-1];
logic [lnk_pkg::CMB_DW-1:0]     pix_ext [0:lnk_pkg::LANES-1];
logic [lnk_pkg::CMB_DW-1:0]     cmb     [0:lnk_pkg::LANES-1];
logic [lnk_pkg::CMB_DW-1:0]     cmb_sh  [0:lnk_pkg::LANES-1];
logic [lnk_pkg::PHY_W-1:0]      word_nxt [0:lnk_pkg::LANES-1];
logic [lnk_pkg::PHY_W-1:0]      word_q   [0:lnk_pkg::LANES-1];

assign pop_o = buf_vld_i & phy_rdy_i;

// Four bytes per lane make one word
assign total = res_cnt + lnk_pkg::POP_CNT;
assign emit = (total >= lnk_pkg::WORD_CNT);

always_comb
begin
    for (int l = 0; l < lnk_pkg::LANES; l++)
    begin
        // Residue first, stale bytes above the count masked off
        res_ext[l] = '0;
        res_ext[l][lnk_pkg::RES_DW-1:0] = res_dat[l]
            & ~({lnk_pkg::RES_DW{1'b1}} << (res_cnt * lnk_pkg::SYM_W));

        // Lane l carries pixel l as R, G, B
        pix_ext[l] = '0;
        pix_ext[l][lnk_pkg::POP_SYM*lnk_pkg::SYM_W-1:0] = {
            buf_dat_i[vid_pkg::B_LSB + l*vid_pkg::BPC +: vid_pkg::BPC],
            buf_dat_i[vid_pkg::G_LSB + l*vid_pkg::BPC +: vid_pkg::BPC],
            buf_dat_i[vid_pkg::R_LSB + l*vid_pkg::BPC +: vid_pkg::BPC]
        };

        cmb[l] = res_ext[l] | (pix_ext[l] << (res_cnt * lnk_pkg::SYM_W));
        cmb_sh[l] = cmb[l] >> (lnk_pkg::SPL * lnk_pkg::SYM_W);

        // Leftover after a word, or everything when no word goes out
        res_nxt[l] = emit ? cmb_sh[l][lnk_pkg::RES_DW-1:0] : cmb[l][lnk_pkg::RES_DW-1:0];
    end
end

// PHY word formatting with lane swap
always_comb
begin
    for (int l = 0; l < lnk_pkg::LANES; l++)
    begin
        word_nxt[lnk_pkg::LANE_MAP[l]] = '0;
        for (int s = 0; s < lnk_pkg::SPL; s++)
        begin
            // Spare bit and K flag clear, data symbols only
            word_nxt[lnk_pkg::LANE_MAP[l]][s*lnk_pkg::SYM_SLOT_W +: lnk_pkg::SYM_SLOT_W] =
                {2'b00, cmb[l][s*lnk_pkg::SYM_W +: lnk_pkg::SYM_W]};
        end
        word_nxt[lnk_pkg::LANE_MAP[l]][lnk_pkg::DISP_CTL_LSB +: lnk_pkg::SPL] = '0;
        word_nxt[lnk_pkg::LANE_MAP[l]][lnk_pkg::DISP_VAL_LSB +: lnk_pkg::SPL] = '0;
    end
end

// Residue count and word strobe
always_ff @(posedge clk_from_vid_buf)
begin
    if (!SYS_RSTN_IN)
    begin
        res_cnt <= '0;
        phy_vld_o <= 1'b0;
    end
    else
    begin
        phy_vld_o <= pop_o & emit;
        if (pop_o)
            res_cnt <= emit ? total - lnk_pkg::WORD_CNT : total;
    end
end

// Payload
always_ff @(posedge clk_from_vid_buf)
begin
    if (pop_o)
    begin
        res_dat <= res_nxt;
        if (emit)
            word_q <= word_nxt;
    end
end

assign phy_dat0_o = word_q[0];
assign phy_dat1_o = word_q[1];
assign phy_dat2_o = word_q[2];
assign phy_dat3_o = word_q[3];

a_res_max: assert property (@(posedge clk_from_vid_buf) disable iff (!SYS_RSTN_IN)
    res_cnt <= lnk_pkg::RES_MAX);

// A word only follows a pop taken while the PHY was ready
a_vld_rdy: assert property (@(posedge clk_from_vid_buf) disable iff (!SYS_RSTN_IN)
    phy_vld_o |-> $past(phy_rdy_i));

endmodule

`default_nettype wire

// ==== hdl/vid_credit_fifo.sv ====
/* Pixel beat buffer, circular FIFO that returns a credit on every pop */
`timescale 1ns/10ps
`default_nettype none

module vid_credit_fifo
(
    input  wire                         clk_from_vid_buf,
    input  wire                         SYS_RSTN_IN,

    // Write side
    input  wire                         push_i,
    input  wire [vid_pkg::BEAT_W-1:0]   push_dat_i,

    // Read side
    input  wire                         pop_i,
    output logic                        buf_vld_o,      // Not empty
    output logic [vid_pkg::BEAT_W-1:0]  buf_dat_o,      // Head entry
    output logic                        crd_ret_o
);

logic [vid_pkg::BEAT_W-1:0]     mem [0:vid_pkg::FIFO_DEPTH-1];
logic [vid_pkg::FIFO_AW-1:0]    wr_ptr;
logic [vid_pkg::FIFO_AW-1:0]    rd_ptr;
logic [vid_pkg::CRD_W-1:0]      cnt;
logic                           full;

assign full = (cnt == vid_pkg::FIFO_DEPTH);

// Storage
always_ff @(posedge clk_from_vid_buf)
begin
    if (push_i)
        mem[wr_ptr] <= push_dat_i;
end

// Pointers and occupancy
always_ff @(posedge clk_from_vid_buf)
begin
    if (!SYS_RSTN_IN)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        cnt <= '0;
    end
    else
    begin
        if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
        if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;

        case ({push_i, pop_i})
            2'b10   : cnt <= cnt + 1'b1;
            2'b01   : cnt <= cnt - 1'b1;
            default : cnt <= cnt;
        endcase
    end
end

assign buf_vld_o = (cnt != '0);
assign buf_dat_o = mem[rd_ptr];
assign crd_ret_o = pop_i;           // Slot freed this cycle

// Producer credit must keep the buffer from filling past its depth
a_no_push_full: assert property (@(posedge clk_from_vid_buf) disable iff (!SYS_RSTN_IN)
    push_i |-> !full);

// Consumer only reads a valid head
a_no_pop_empty: assert property (@(posedge clk_from_vid_buf) disable iff (!SYS_RSTN_IN)
    pop_i |-> buf_vld_o);

endmodule

`default_nettype wire

// ==== hdl/vid_src_sel.sv ====
/* Video producer: selects external pixels or colour bars and
   pushes beats into the pixel buffer against a credit count */
`timescale 1ns/10ps
`default_nettype none

module vid_src_sel
(
    input  wire                         clk_from_vid_buf,
    input  wire                         SYS_RSTN_IN,

    // Source select, asynchronous
    input  wire                         src_sel_i,      // 1 external, 0 colour bars

    // External source
    input  wire                         ext_de_i,
    input  wire [vid_pkg::COMP_W-1:0]   ext_r_i,
    input  wire [vid_pkg::COMP_W-1:0]   ext_g_i,
    input  wire [vid_pkg::COMP_W-1:0]   ext_b_i,

    // Buffer side
    input  wire                         crd_ret_i,      // One credit per pop
    output logic                        push_o,
    output logic [vid_pkg::BEAT_W-1:0]  push_dat_o,

    output logic                        ovf_o           // Sticky, external beat lost
);

logic                               sel_meta;
logic                               sel_ext;
logic [vid_pkg::CRD_W-1:0]          crd_cnt;
logic                               crd_ok;
logic [vid_pkg::BIDX_W-1:0]         bar_idx;
logic [vid_pkg::BAR_SEL_W-1:0]      bar_sel;
logic [23:0]                        bar_rgb;
logic [vid_pkg::BEAT_W-1:0]         bar_beat;
logic [vid_pkg::BEAT_W-1:0]         ext_beat;

// Mode select synchronizer
always_ff @(posedge clk_from_vid_buf)
begin
    if (!SYS_RSTN_IN)
    begin
        sel_meta <= 1'b0;
        sel_ext <= 1'b0;
    end
    else
    begin
        sel_meta <= src_sel_i;
        sel_ext <= sel_meta;
    end
end

assign crd_ok = (crd_cnt != '0);

// Bar number is the upper part of the beat index
assign bar_sel = bar_idx[vid_pkg::BIDX_W-1 -: vid_pkg::BAR_SEL_W];
assign bar_rgb = vid_pkg::BAR_COLORS[bar_sel];

// All four pixels of a bar beat share one colour
always_comb
begin
    bar_beat = '0;
    bar_beat[vid_pkg::R_LSB +: vid_pkg::COMP_W] = {vid_pkg::PPC{bar_rgb[23:16]}};
    bar_beat[vid_pkg::G_LSB +: vid_pkg::COMP_W] = {vid_pkg::PPC{bar_rgb[15:8]}};
    bar_beat[vid_pkg::B_LSB +: vid_pkg::COMP_W] = {vid_pkg::PPC{bar_rgb[7:0]}};
end

assign ext_beat = {ext_b_i, ext_g_i, ext_r_i};

// Source mux, beat is written by the buffer on the next edge
always_comb
begin
    if (sel_ext)
    begin
        push_o = ext_de_i & crd_ok;
        push_dat_o = ext_beat;
    end
    else
    begin
        push_o = crd_ok;            // Bars run whenever credit is left
        push_dat_o = bar_beat;
    end
end

// Bar position, paused without credit
always_ff @(posedge clk_from_vid_buf)
begin
    if (!SYS_RSTN_IN)
        bar_idx <= '0;
    else if (sel_ext)
        bar_idx <= '0;
    else if (crd_ok)
        bar_idx <= bar_idx + 1'b1;  // Wraps at end of line
end

// Credit counter
always_ff @(posedge clk_from_vid_buf)
begin
    if (!SYS_RSTN_IN)
        crd_cnt <= vid_pkg::FIFO_DEPTH;
    else
    begin
        case ({push_o, crd_ret_i})
            2'b10   : crd_cnt <= crd_cnt - 1'b1;
            2'b01   : crd_cnt <= crd_cnt + 1'b1;
            default : crd_cnt <= crd_cnt;
        endcase
    end
end

// Overflow flag
always_ff @(posedge clk_from_vid_buf)
begin
    if (!SYS_RSTN_IN)
        ovf_o <= 1'b0;
    else if (sel_ext && ext_de_i && !crd_ok)
        ovf_o <= 1'b1;
end

// Credits only come back for beats that were pushed
a_crd_max: assert property (@(posedge clk_from_vid_buf) disable iff (!SYS_RSTN_IN)
    crd_cnt <= vid_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

// ==== hdl/lnk_pkg.sv ====
/* Link side definitions: lane and symbol counts, PHY transmit word layout and lane map */
`default_nettype none

package lnk_pkg;

    // Main link
    localparam int LANES = 4;
    localparam int SPL   = 4;                   // Symbols per lane per word
    localparam int SYM_W = 8;                   // Data byte of a symbol

    // PHY word, one 10-bit slot per symbol: data, K flag, spare
    localparam int SYM_SLOT_W   = 10;
    localparam int PHY_W        = 80;
    localparam int DISP_CTL_LSB = 40;           // 0 automatic, 1 forced
    localparam int DISP_VAL_LSB = 44;           // 0 negative, 1 positive

    // Repacking, each lane gains R, G and B per pixel beat
    localparam int POP_SYM = 3;
    localparam int RES_DW  = (SPL - 1) * SYM_W;
    localparam int CMB_DW  = RES_DW + POP_SYM * SYM_W;

    // Residue byte counter
    localparam int RES_W = 3;
    localparam logic [RES_W-1:0] RES_MAX  = RES_W'(SPL - 1);
    localparam logic [RES_W-1:0] POP_CNT  = RES_W'(POP_SYM);
    localparam logic [RES_W-1:0] WORD_CNT = RES_W'(SPL);

    // Link lane to PHY word index
    localparam int LANE_MAP [0:LANES-1] = '{1, 0, 2, 3};

endpackage

`default_nettype wire

// ==== hdl/vid_pkg.sv ====
/* Video side definitions: pixel beat format, colour-bar pattern and pixel buffer sizing */
`default_nettype none

package vid_pkg;

    // Pixel format
    localparam int PPC    = 4;                  // Pixels per clock
    localparam int BPC    = 8;                  // Bits per component
    localparam int COMP_W = PPC * BPC;          // One component bus
    localparam int BEAT_W = 3 * COMP_W;         // R, G and B of one beat

    // Beat layout, pixel p of a component sits at LSB + p*BPC
    localparam int R_LSB = 0;
    localparam int G_LSB = COMP_W;
    localparam int B_LSB = 2 * COMP_W;

    // Pixel buffer and credits
    localparam int CRD_W = 4;
    localparam logic [CRD_W-1:0] FIFO_DEPTH = CRD_W'(8);
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // Colour bars
    localparam int LINE_BEATS = 64;
    localparam int BAR_BEATS  = 8;
    localparam int BIDX_W     = $clog2(LINE_BEATS);
    localparam int BAR_SEL_W  = $clog2(LINE_BEATS / BAR_BEATS);

    // Bar colours as {R, G, B}
    localparam logic [23:0] BAR_COLORS [0:7] = '{
        24'hFFFFFF,     // White
        24'hFFFF00,     // Yellow
        24'h00FFFF,     // Cyan
        24'h00FF00,     // Green
        24'hFF00FF,     // Magenta
        24'hFF0000,     // Red
        24'h0000FF,     // Blue
        24'h000000      // Black
    };

endpackage

`default_nettype wire
